/* Bender.yml */
package:
  name: udma_channel

sources:
  # Packages first, then RTL in dependency order
  - files:
      - hw/udma_regmap_pkg.sv
      - hw/udma_stream_pkg.sv
      - hw/udma_cfg_regs.sv
      - hw/udma_l2_mem.sv
      - hw/udma_rx_sink.sv
      - hw/udma_tx_streamer.sv
      - hw/udma_channel_top.sv

  - target: test
    files:
      - verification/tb_udma_channel_top.sv

/* hw/udma_cfg_regs.sv */
`timescale 1ns/1ps
// uDMA channel configuration register bank
// Decodes the config bus, holds RX/TX setup, issues start and clear pulses
module udma_cfg_regs import udma_regmap_pkg::*, udma_stream_pkg::*; (
    input  logic         sys_clk,
    input  logic         rst_n,
    input  cfg_req_t     cfg_req_i,
    input  chan_status_t rx_status_i,
    input  chan_status_t tx_status_i,
    output udma_word_t   cfg_rdata_o,
    output logic         cfg_ready_o,
    output chan_cfg_t    rx_cfg_o,
    output chan_cfg_t    tx_cfg_o,
    output logic         rx_start_o,
    output logic         rx_clr_o,
    output logic         tx_start_o,
    output logic         tx_clr_o
);

    logic        ready_q;
    logic        req_fire;
    logic        wr_fire;
    logic        en_req;
    logic        clr_req;
    l2_addr_t    wr_addr;
    trans_size_t wr_size;
    udma_word_t  rdata_d;
    udma_word_t  rdata_q;
    chan_cfg_t   rx_cfg_q;
    chan_cfg_t   tx_cfg_q;
    logic        rx_start_q;
    logic        rx_clr_q;
    logic        tx_start_q;
    logic        tx_clr_q;

    assign req_fire = cfg_req_i.valid & ~ready_q;  // One accept per request
    assign wr_fire  = req_fire & ~cfg_req_i.rwn;
    assign clr_req  = cfg_req_i.wdata[CFG_CLR_BIT];
    assign en_req   = cfg_req_i.wdata[CFG_EN_BIT] & ~clr_req; // Clear has priority
    assign wr_addr  = {cfg_req_i.wdata[L2_AWIDTH-1:2], 2'b00};
    assign wr_size  = (cfg_req_i.wdata[TRANS_SIZE-1:0] + trans_size_t'(3)) & ~trans_size_t'(3);

    //////////////////////////////
    // Readback mux
    //////////////////////////////
    always_comb begin
        rdata_d = '0;
        case (cfg_req_i.addr)
            REG_RX_SADDR:   rdata_d[L2_AWIDTH-1:0]  = rx_cfg_q.start_addr;
            REG_RX_SIZE:    rdata_d[TRANS_SIZE-1:0] = rx_status_i.bytes_left;
            REG_UDMA_RXCFG: rdata_d[CFG_EN_BIT]     = rx_status_i.busy;
            REG_TX_SADDR:   rdata_d[L2_AWIDTH-1:0]  = tx_cfg_q.start_addr;
            REG_TX_SIZE:    rdata_d[TRANS_SIZE-1:0] = tx_status_i.bytes_left;
            REG_UDMA_TXCFG: rdata_d[CFG_EN_BIT]     = tx_status_i.busy;
            REG_STATUS:     rdata_d[1:0]            = {tx_status_i.busy, rx_status_i.busy};
            default:        rdata_d = '0;           // Unmapped
        endcase
    end

    always_ff @(posedge sys_clk) begin
        if (req_fire) begin
            rdata_q <= rdata_d;   // Valid in the ready cycle
        end
    end

    //////////////////////////////
    // Register writes and pulses
    //////////////////////////////
    always_ff @(posedge sys_clk or negedge rst_n) begin
        if (!rst_n) begin
            ready_q    <= 1'b0;
            rx_cfg_q   <= '0;
            tx_cfg_q   <= '0;
            rx_start_q <= 1'b0;
            rx_clr_q   <= 1'b0;
            tx_start_q <= 1'b0;
            tx_clr_q   <= 1'b0;
        end else begin
            ready_q    <= req_fire;
            rx_start_q <= 1'b0;
            rx_clr_q   <= 1'b0;
            tx_start_q <= 1'b0;
            tx_clr_q   <= 1'b0;
            if (wr_fire) begin
                case (cfg_req_i.addr)
                    REG_RX_SADDR: rx_cfg_q.start_addr <= wr_addr;
                    REG_RX_SIZE:  rx_cfg_q.size       <= wr_size;
                    REG_UDMA_RXCFG: begin
                        rx_start_q <= en_req & (rx_cfg_q.size != '0);
                        rx_clr_q   <= clr_req;
                    end
                    REG_TX_SADDR: tx_cfg_q.start_addr <= wr_addr;
                    REG_TX_SIZE:  tx_cfg_q.size       <= wr_size;
                    REG_UDMA_TXCFG: begin
                        tx_start_q <= en_req & (tx_cfg_q.size != '0);
                        tx_clr_q   <= clr_req;
                    end
                    default: ;    // Writes elsewhere are ignored
                endcase
            end
        end
    end

    assign cfg_rdata_o = rdata_q;
    assign cfg_ready_o = ready_q;
    assign rx_cfg_o    = rx_cfg_q;
    assign tx_cfg_o    = tx_cfg_q;
    assign rx_start_o  = rx_start_q;
    assign rx_clr_o    = rx_clr_q;
    assign tx_start_o  = tx_start_q;
    assign tx_clr_o    = tx_clr_q;

endmodule

/* hw/udma_channel_top.sv */
`timescale 1ns/1ps
// uDMA channel top level
// Register bank, L2 memory, RX sink and TX streamer
module udma_channel_top import udma_regmap_pkg::*, udma_stream_pkg::*; (
    input  logic       sys_clk,
    input  logic       rst_n,
    input  cfg_req_t   cfg_req_i,
    output udma_word_t cfg_rdata_o,
    output logic       cfg_ready_o,
    input  udma_word_t rx_data_i,
    input  logic       rx_valid_i,
    output udma_word_t tx_data_o,
    output logic       tx_valid_o,
    input  logic       tx_ready_i
);

    chan_cfg_t    rx_cfg;
    chan_cfg_t    tx_cfg;
    chan_status_t rx_status;
    chan_status_t tx_status;
    logic         rx_start;
    logic         rx_clr;
    logic         tx_start;
    logic         tx_clr;
    logic         mem_we;
    l2_addr_t     mem_waddr;
    udma_word_t   mem_wdata;
    logic         mem_re;
    l2_addr_t     mem_raddr;
    udma_word_t   mem_rdata;

    udma_cfg_regs i_udma_cfg_regs (
        .sys_clk     (sys_clk),
        .rst_n       (rst_n),
        .cfg_req_i   (cfg_req_i),
        .rx_status_i (rx_status),
        .tx_status_i (tx_status),
        .cfg_rdata_o (cfg_rdata_o),
        .cfg_ready_o (cfg_ready_o),
        .rx_cfg_o    (rx_cfg),
        .tx_cfg_o    (tx_cfg),
        .rx_start_o  (rx_start),
        .rx_clr_o    (rx_clr),
        .tx_start_o  (tx_start),
        .tx_clr_o    (tx_clr)
    );

    udma_l2_mem i_udma_l2_mem (
        .sys_clk (sys_clk),
        .we_i    (mem_we),
        .waddr_i (mem_waddr),
        .wdata_i (mem_wdata),
        .re_i    (mem_re),
        .raddr_i (mem_raddr),
        .rdata_o (mem_rdata)
    );

    udma_rx_sink i_udma_rx_sink (
        .sys_clk     (sys_clk),
        .rst_n       (rst_n),
        .cfg_i       (rx_cfg),
        .start_i     (rx_start),
        .clr_i       (rx_clr),
        .rx_data_i   (rx_data_i),
        .rx_valid_i  (rx_valid_i),
        .status_o    (rx_status),
        .mem_we_o    (mem_we),
        .mem_waddr_o (mem_waddr),
        .mem_wdata_o (mem_wdata)
    );

    udma_tx_streamer i_udma_tx_streamer (
        .sys_clk     (sys_clk),
        .rst_n       (rst_n),
        .cfg_i       (tx_cfg),
        .start_i     (tx_start),
        .clr_i       (tx_clr),
        .mem_rdata_i (mem_rdata),
        .tx_ready_i  (tx_ready_i),
        .status_o    (tx_status),
        .mem_re_o    (mem_re),
        .mem_raddr_o (mem_raddr),
        .tx_data_o   (tx_data_o),
        .tx_valid_o  (tx_valid_o)
    );

endmodule

/* hw/udma_l2_mem.sv */
`timescale 1ns/1ps
// L2 word memory
// One write port and a registered read port that returns old data on a collision
module udma_l2_mem import udma_stream_pkg::*; (
    input  logic       sys_clk,
    input  logic       we_i,
    input  l2_addr_t   waddr_i,
    input  udma_word_t wdata_i,
    input  logic       re_i,
    input  l2_addr_t   raddr_i,
    output udma_word_t rdata_o
);

    udma_word_t mem_q [MEM_WORDS];
    udma_word_t rdata_q;

    always_ff @(posedge sys_clk) begin
        if (we_i) begin
            mem_q[waddr_i[L2_AWIDTH-1:2]] <= wdata_i;  // Byte address to word index
        end
        if (re_i) begin
            rdata_q <= mem_q[raddr_i[L2_AWIDTH-1:2]];  // Held until next read
        end
    end

    assign rdata_o = rdata_q;

endmodule

/* hw/udma_regmap_pkg.sv */
// uDMA channel register map
// Register offsets, config-word bit positions and the config bus request
package udma_regmap_pkg;

    //////////////////////////////
    // Register offsets
    //////////////////////////////
    localparam int unsigned REG_AWIDTH = 5;

    localparam logic [REG_AWIDTH-1:0] REG_RX_SADDR   = 5'd0; // L2 start address for RX
    localparam logic [REG_AWIDTH-1:0] REG_RX_SIZE    = 5'd1; // RX byte count
    localparam logic [REG_AWIDTH-1:0] REG_UDMA_RXCFG = 5'd2; // RX enable and clear
    localparam logic [REG_AWIDTH-1:0] REG_TX_SADDR   = 5'd3; // L2 start address for TX
    localparam logic [REG_AWIDTH-1:0] REG_TX_SIZE    = 5'd4; // TX byte count
    localparam logic [REG_AWIDTH-1:0] REG_UDMA_TXCFG = 5'd5; // TX enable and clear
    localparam logic [REG_AWIDTH-1:0] REG_STATUS     = 5'd9; // Busy flags

    // Bit positions inside the RXCFG/TXCFG word
    localparam int unsigned CFG_EN_BIT  = 4;
    localparam int unsigned CFG_CLR_BIT = 5;

    //////////////////////////////
    // Config bus request
    //////////////////////////////
    typedef struct packed {
        logic [REG_AWIDTH-1:0] addr;
        logic [31:0]           wdata;
        logic                  valid;
        logic                  rwn;   // High for a read
    } cfg_req_t;

endpackage

/* hw/udma_rx_sink.sv */
`timescale 1ns/1ps
// uDMA RX channel
// Writes each received word to L2 and counts down the bytes left
module udma_rx_sink import udma_stream_pkg::*; (
    input  logic         sys_clk,
    input  logic         rst_n,
    input  chan_cfg_t    cfg_i,
    input  logic         start_i,
    input  logic         clr_i,
    input  udma_word_t   rx_data_i,
    input  logic         rx_valid_i,
    output chan_status_t status_o,
    output logic         mem_we_o,
    output l2_addr_t     mem_waddr_o,
    output udma_word_t   mem_wdata_o
);

    logic        busy_q;
    l2_addr_t    addr_q;
    trans_size_t left_q;
    logic        accept;

    assign accept = busy_q & rx_valid_i;  // Idle words are dropped

    always_ff @(posedge sys_clk or negedge rst_n) begin
        if (!rst_n) begin
            busy_q <= 1'b0;
            addr_q <= '0;
            left_q <= '0;
        end else if (clr_i) begin
            busy_q <= 1'b0;
            left_q <= '0;
        end else if (start_i) begin
            busy_q <= 1'b1;
            addr_q <= cfg_i.start_addr;
            left_q <= cfg_i.size;
        end else if (accept) begin
            addr_q <= addr_q + l2_addr_t'(4);
            left_q <= left_q - trans_size_t'(4);
            if (left_q == trans_size_t'(4)) begin
                busy_q <= 1'b0;   // Last word of the buffer
            end
        end
    end

    assign mem_we_o    = accept;
    assign mem_waddr_o = addr_q;
    assign mem_wdata_o = rx_data_i;

    assign status_o.busy       = busy_q;
    assign status_o.bytes_left = left_q;

endmodule

/* hw/udma_stream_pkg.sv */
// uDMA channel stream definitions
// L2 sizes, the stream word and the per-channel setup and state
package udma_stream_pkg;

    //////////////////////////////
    // Sizes
    //////////////////////////////
    localparam int unsigned L2_AWIDTH  = 12;   // Byte address into 4 KB of L2
    localparam int unsigned TRANS_SIZE = 16;   // Byte count field
    localparam int unsigned MEM_WORDS  = 1024; // L2 depth in 32-bit words

    typedef logic [31:0]           udma_word_t;
    typedef logic [L2_AWIDTH-1:0]  l2_addr_t;
    typedef logic [TRANS_SIZE-1:0] trans_size_t;

    //////////////////////////////
    // Channel setup and state
    //////////////////////////////
    typedef struct packed {
        l2_addr_t    start_addr; // Word aligned
        trans_size_t size;       // Multiple of 4
    } chan_cfg_t;

    typedef struct packed {
        logic        busy;
        trans_size_t bytes_left;
    } chan_status_t;

endpackage

/* hw/udma_tx_streamer.sv */
`timescale 1ns/1ps
// uDMA TX channel
// Prefetches words from L2 and streams them out under valid/ready
module udma_tx_streamer import udma_stream_pkg::*; (
    input  logic         sys_clk,
    input  logic         rst_n,
    input  chan_cfg_t    cfg_i,
    input  logic         start_i,
    input  logic         clr_i,
    input  udma_word_t   mem_rdata_i,
    input  logic         tx_ready_i,
    output chan_status_t status_o,
    output logic         mem_re_o,
    output l2_addr_t     mem_raddr_o,
    output udma_word_t   tx_data_o,
    output logic         tx_valid_o
);

    logic        busy_q;
    l2_addr_t    fetch_addr_q;
    trans_size_t fetch_left_q;  // Bytes not yet requested from L2
    trans_size_t left_q;        // Bytes not yet accepted by the sink
    logic        mem_vld_q;     // Memory read register holds an unused word
    logic        out_valid_q;
    udma_word_t  out_data_q;
    logic        accept;
    logic        move;
    logic        issue;

    assign accept = out_valid_q & tx_ready_i;
    assign move   = mem_vld_q & (~out_valid_q | tx_ready_i);      // Fill the output slot
    assign issue  = busy_q & (fetch_left_q != '0) & (~mem_vld_q | move);

    //////////////////////////////
    // Fetch and output control
    //////////////////////////////
    always_ff @(posedge sys_clk or negedge rst_n) begin
        if (!rst_n) begin
            busy_q       <= 1'b0;
            fetch_addr_q <= '0;
            fetch_left_q <= '0;
            left_q       <= '0;
            mem_vld_q    <= 1'b0;
            out_valid_q  <= 1'b0;
        end else if (clr_i) begin
            busy_q       <= 1'b0;
            fetch_left_q <= '0;
            left_q       <= '0;
            mem_vld_q    <= 1'b0;
            out_valid_q  <= 1'b0;
        end else if (start_i) begin
            busy_q       <= 1'b1;
            fetch_addr_q <= cfg_i.start_addr;
            fetch_left_q <= cfg_i.size;
            left_q       <= cfg_i.size;
            mem_vld_q    <= 1'b0;
            out_valid_q  <= 1'b0;
        end else begin
            if (issue) begin
                fetch_addr_q <= fetch_addr_q + l2_addr_t'(4);
                fetch_left_q <= fetch_left_q - trans_size_t'(4);
            end
            mem_vld_q <= issue | (mem_vld_q & ~move);
            if (move) begin
                out_valid_q <= 1'b1;
            end else if (accept) begin
                out_valid_q <= 1'b0;
            end
            if (accept) begin
                left_q <= left_q - trans_size_t'(4);
                if (left_q == trans_size_t'(4)) begin
                    busy_q <= 1'b0;   // Last word taken
                end
            end
        end
    end

    always_ff @(posedge sys_clk) begin
        if (move) begin
            out_data_q <= mem_rdata_i;  // Held under back-pressure
        end
    end

    assign mem_re_o    = issue;
    assign mem_raddr_o = fetch_addr_q;
    assign tx_data_o   = out_data_q;
    assign tx_valid_o  = out_valid_q;

    assign status_o.busy       = busy_q;
    assign status_o.bytes_left = left_q;

endmodule

/* udma_channel_top.f */
hw/udma_regmap_pkg.sv
hw/udma_stream_pkg.sv
hw/udma_cfg_regs.sv
hw/udma_l2_mem.sv
hw/udma_rx_sink.sv
hw/udma_tx_streamer.sv
hw/udma_channel_top.sv
verification/tb_udma_channel_top.sv

/* verification/tb_udma_channel_top.sv */
`timescale 1ns/1ps
// Testbench for the uDMA channel top level
// Table-driven register, RX fill, TX loopback, back-pressure and clear tests
module tb_udma_channel_top import udma_regmap_pkg::*, udma_stream_pkg::*; ();

    localparam int OP_WR    = 0;  // Config write
    localparam int OP_RD    = 1;  // Config read with expected data in value
    localparam int OP_RX    = 2;  // RX burst to L2 byte address in value
    localparam int OP_RXIDL = 3;  // Words sent while RX is idle
    localparam int OP_TX    = 4;  // TX drain with ready held high
    localparam int OP_TXRND = 5;  // TX drain with random ready
    localparam int OP_VWAIT = 6;  // Wait for tx_valid_o
    localparam int OP_VLOW  = 7;  // tx_valid_o low for count cycles
    localparam int ROW_MARGIN = 40;

    typedef struct packed {
        logic [2:0]  op;
        logic [4:0]  addr;
        logic [31:0] value;
        logic [15:0] count;
    } row_t;

    logic        sys_clk;
    logic        rst_n;
    cfg_req_t    cfg_req;
    udma_word_t  cfg_rdata;
    logic        cfg_ready;
    udma_word_t  rx_data;
    logic        rx_valid;
    udma_word_t  tx_data;
    logic        tx_valid;
    logic        tx_ready;
    row_t        rows[$];
    udma_word_t  model_mem [MEM_WORDS];  // Expected L2 contents
    logic [31:0] rng_state = 32'h0db3_773e;
    int          errors = 0;
    int          checks = 0;
    int          cycles = 0;
    int          cycle_limit;

    udma_channel_top i_udma_channel_top (
        .sys_clk     (sys_clk),
        .rst_n       (rst_n),
        .cfg_req_i   (cfg_req),
        .cfg_rdata_o (cfg_rdata),
        .cfg_ready_o (cfg_ready),
        .rx_data_i   (rx_data),
        .rx_valid_i  (rx_valid),
        .tx_data_o   (tx_data),
        .tx_valid_o  (tx_valid),
        .tx_ready_i  (tx_ready)
    );

    always #5 sys_clk = ~sys_clk;

    always @(posedge sys_clk) begin
        cycles <= cycles + 1;
        if (cycles >= cycle_limit) begin
            $display("Timeout: the table did not finish within %0d cycles", cycle_limit);
            $display("*** TEST FAILED ***");
            $finish;
        end
    end

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic void add_row(input int op, input logic [4:0] addr,
                                    input logic [31:0] value, input int count);
        row_t r;
        r.op    = op[2:0];
        r.addr  = addr;
        r.value = value;
        r.count = count[15:0];
        rows.push_back(r);
    endfunction

    task automatic check_value(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
        checks++;
        if (exp !== act) begin
            errors++;
            $display("FAIL %0t %s expected %h got %h", $time, name, exp, act);
        end
    endtask

    //////////////////////////////
    // Bus and stream drivers
    //////////////////////////////
    task automatic cfg_access(input logic rwn, input logic [4:0] addr,
                              input logic [31:0] wdata, output logic [31:0] rdata);
        @(negedge sys_clk);
        check_value("cfg_ready_o", 32'd0, {31'd0, cfg_ready});  // Last pulse is over
        cfg_req.addr  = addr;
        cfg_req.wdata = wdata;
        cfg_req.rwn   = rwn;
        cfg_req.valid = 1'b1;
        do @(negedge sys_clk); while (!cfg_ready);  // Held until the ready pulse
        rdata = cfg_rdata;
        cfg_req.valid = 1'b0;
    endtask

    task automatic rx_burst(input logic [31:0] base, input int count, input logic record);
        for (int n = 0; n < count; n++) begin
            @(negedge sys_clk);
            rng_state = xorshift(rng_state);
            rx_data   = rng_state;
            rx_valid  = 1'b1;
            if (record) begin
                model_mem[int'(base[L2_AWIDTH-1:2]) + n] = rng_state;
            end
        end
        @(negedge sys_clk);
        rx_valid = 1'b0;
    endtask

    task automatic tx_drain(input logic [31:0] base, input int count, input logic random);
        int got;
        got = 0;
        while (got < count) begin
            @(negedge sys_clk);
            rng_state = xorshift(rng_state);
            tx_ready  = random ? rng_state[7] : 1'b1;
            if (tx_valid && tx_ready) begin  // Transfers on the next rising edge
                check_value("tx_data_o", model_mem[int'(base[L2_AWIDTH-1:2]) + got], tx_data);
                got++;
            end
        end
        @(negedge sys_clk);
        tx_ready = 1'b0;
        check_value("tx_valid_o", 32'd0, {31'd0, tx_valid});  // No extra word
    endtask

    task automatic expect_valid_low(input int count);
        repeat (count) begin
            @(negedge sys_clk);
            check_value("tx_valid_o", 32'd0, {31'd0, tx_valid});
        end
    endtask

    //////////////////////////////
    // Test table and run
    //////////////////////////////
    initial begin
        logic [31:0] rdata;
        int          total;
        sys_clk  = 1'b0;
        rst_n    = 1'b0;
        cfg_req  = '0;
        rx_data  = '0;
        rx_valid = 1'b0;
        tx_ready = 1'b0;
        add_row(OP_WR,    REG_RX_SADDR,   32'h103, 0);   // Unaligned addresses
        add_row(OP_WR,    REG_TX_SADDR,   32'h102, 0);
        add_row(OP_RD,    REG_RX_SADDR,   32'h100, 0);
        add_row(OP_RD,    REG_TX_SADDR,   32'h100, 0);
        add_row(OP_WR,    5'd7,           32'hdead_beef, 0);
        add_row(OP_RD,    5'd7,           32'h0, 0);     // Unmapped
        add_row(OP_WR,    REG_RX_SIZE,    32'd64, 0);    // RX fill
        add_row(OP_WR,    REG_UDMA_RXCFG, 32'h10, 0);
        add_row(OP_RX,    5'd0,           32'h100, 16);
        add_row(OP_RD,    REG_STATUS,     32'h0, 0);
        add_row(OP_RD,    REG_RX_SIZE,    32'h0, 0);
        add_row(OP_WR,    REG_TX_SIZE,    32'd64, 0);    // Loopback
        add_row(OP_WR,    REG_UDMA_TXCFG, 32'h10, 0);
        add_row(OP_TX,    5'd0,           32'h100, 16);
        add_row(OP_RD,    REG_STATUS,     32'h0, 0);
        add_row(OP_WR,    REG_UDMA_TXCFG, 32'h10, 0);    // Back-pressure
        add_row(OP_TXRND, 5'd0,           32'h100, 16);
        add_row(OP_RD,    REG_STATUS,     32'h0, 0);
        add_row(OP_WR,    REG_RX_SIZE,    32'd10, 0);    // Rounds up to 12
        add_row(OP_WR,    REG_UDMA_RXCFG, 32'h10, 0);
        add_row(OP_RD,    REG_RX_SIZE,    32'd12, 0);
        add_row(OP_RX,    5'd0,           32'h100, 3);
        add_row(OP_RXIDL, 5'd0,           32'h0, 2);
        add_row(OP_RD,    REG_STATUS,     32'h0, 0);
        add_row(OP_WR,    REG_TX_SIZE,    32'd16, 0);
        add_row(OP_WR,    REG_UDMA_TXCFG, 32'h10, 0);
        add_row(OP_TX,    5'd0,           32'h100, 4);
        add_row(OP_WR,    REG_TX_SIZE,    32'd64, 0);    // Clear with ready low
        add_row(OP_WR,    REG_UDMA_TXCFG, 32'h10, 0);
        add_row(OP_VWAIT, 5'd0,           32'h0, 0);
        add_row(OP_WR,    REG_UDMA_TXCFG, 32'h30, 0);    // Clear beats enable
        add_row(OP_VLOW,  5'd0,           32'h0, 8);
        add_row(OP_RD,    REG_STATUS,     32'h0, 0);
        add_row(OP_RD,    REG_TX_SIZE,    32'h0, 0);
        total = 0;
        foreach (rows[i]) begin
            total += int'(rows[i].count);
        end
        cycle_limit = 4 * total + ROW_MARGIN * rows.size() + 10;

        repeat (3) @(posedge sys_clk);
        @(negedge sys_clk);
        rst_n = 1'b1;

        foreach (rows[i]) begin
            case (int'(rows[i].op))
                OP_WR:    cfg_access(1'b0, rows[i].addr, rows[i].value, rdata);
                OP_RD: begin
                    cfg_access(1'b1, rows[i].addr, 32'h0, rdata);
                    check_value("cfg_rdata_o", rows[i].value, rdata);
                end
                OP_RX:    rx_burst(rows[i].value, rows[i].count, 1'b1);
                OP_RXIDL: rx_burst(rows[i].value, rows[i].count, 1'b0);
                OP_TX:    tx_drain(rows[i].value, rows[i].count, 1'b0);
                OP_TXRND: tx_drain(rows[i].value, rows[i].count, 1'b1);
                OP_VWAIT: begin
                    do @(negedge sys_clk); while (!tx_valid);
                end
                default:  expect_valid_low(rows[i].count);
            endcase
        end

        repeat (2) @(negedge sys_clk);
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule
